/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tenyrTb -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* all.f */
hdl/tenyrPkg.sv
hdl/wordRam.sv
hdl/insnDecode.sv
hdl/execUnit.sv
hdl/regFile.sv
hdl/coreSeq.sv
hdl/tenyrTop.sv
verif/tenyrChecker.sv
verif/tenyrCore_properties.sv
verif/tenyrTb.sv

/* hdl/coreSeq.sv */
`timescale 1ns/1ps

module coreSeq #(
    parameter int             ADDR_W       = 8,
    parameter tenyrPkg::wordT RESET_VECTOR = tenyrPkg::DEFAULT_RESET_VECTOR
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              run,
    output logic [ADDR_W-1:0] pc,
    input  tenyrPkg::insnT    insn,
    output logic [ADDR_W-1:0] dAddr,
    output logic              dWrite,
    output tenyrPkg::wordT    dOut,
    input  tenyrPkg::wordT    dIn,
    output logic              halt
);

    import tenyrPkg::*;

    regIdxT     idxZ, idxX, idxY;
    aluOpE      op;
    wordT       imm, valZ, valX, valY, rhs;
    wordT       opRight, addend, wbVal, addrWord, nextPc;
    logic       immRight, storing, derefRhs, branch, illegal;
    logic [1:0] cycRing;  // 01 execute, 10 commit, 00 idle
    logic       execPhase, commitPhase, stopNow;
    logic       haltQ;

    assign execPhase   = run && cycRing[0];
    assign commitPhase = run && cycRing[1];
    assign stopNow     = haltQ || (execPhase && illegal);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc      <= RESET_VECTOR[ADDR_W-1:0];
            haltQ   <= 1'b0;
            cycRing <= 2'b00;  // Start delay before first execute
        end else if (run) begin
            haltQ   <= stopNow;
            cycRing <= stopNow ? 2'b00 : (cycRing[0] ? 2'b10 : 2'b01);
            if (commitPhase) begin
                pc <= branch ? wbVal[ADDR_W-1:0] : nextPc[ADDR_W-1:0];
            end
        end
    end

    assign halt   = haltQ;
    assign nextPc = 32'(pc) + 32'd1;

    insnDecode uDecode (
        .insn     (insn),
        .idxZ     (idxZ),
        .idxX     (idxX),
        .idxY     (idxY),
        .op       (op),
        .imm      (imm),
        .immRight (immRight),
        .storing  (storing),
        .derefRhs (derefRhs),
        .branch   (branch),
        .illegal  (illegal)
    );

    // Immediate and register Y swap between right operand and addend
    assign opRight = immRight ? imm  : valY;
    assign addend  = immRight ? valY : imm;

    execUnit uExec (
        .clk    (clk),
        .en     (execPhase),
        .op     (op),
        .opX    (valX),
        .opY    (opRight),
        .addend (addend),
        .rhs    (rhs)
    );

    assign wbVal    = derefRhs ? dIn  : rhs;   // Load or computed value
    assign addrWord = derefRhs ? rhs  : valZ;
    assign dAddr    = addrWord[ADDR_W-1:0];
    assign dOut     = derefRhs ? valZ : rhs;
    assign dWrite   = commitPhase && storing;

    regFile uRegs (
        .clk    (clk),
        .we     (commitPhase && !storing),
        .idxZ   (idxZ),
        .idxX   (idxX),
        .idxY   (idxY),
        .writeZ (wbVal),
        .nextPc (nextPc),
        .valZ   (valZ),
        .valX   (valX),
        .valY   (valY)
    );

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
    input  logic            clk,
    input  logic            en,
    input  tenyrPkg::aluOpE op,
    input  tenyrPkg::wordT  opX,
    input  tenyrPkg::wordT  opY,
    input  tenyrPkg::wordT  addend,
    output tenyrPkg::wordT  rhs
);

    import tenyrPkg::*;

    logic signed [31:0] sX;
    logic signed [31:0] sY;
    wordT               result;

    assign sX = signed'(opX);
    assign sY = signed'(opY);

    always_comb begin
        case (op)
            aluOr:     result = opX | opY;
            aluAnd:    result = opX & opY;
            aluAdd:    result = opX + opY;
            aluMul:    result = opX * opY;            // Low word only
            aluShl:    result = opX << opY[4:0];
            aluCmpLt:  result = {32{sX < sY}};        // True is all ones
            aluCmpEq:  result = {32{sX == sY}};
            aluCmpGt:  result = {32{sX > sY}};
            aluAndNot: result = opX & ~opY;
            aluXor:    result = opX ^ opY;
            aluSub:    result = opX - opY;
            aluXnor:   result = opX ^~ opY;
            aluShr:    result = opX >> opY[4:0];      // Logical shift
            aluCmpNe:  result = {32{sX != sY}};
            default:   result = '0;                   // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rhs <= result + addend;
        end
    end

endmodule

/* hdl/insnDecode.sv */
`timescale 1ns/1ps

module insnDecode (
    input  tenyrPkg::insnT   insn,
    output tenyrPkg::regIdxT idxZ,
    output tenyrPkg::regIdxT idxX,
    output tenyrPkg::regIdxT idxY,
    output tenyrPkg::aluOpE  op,
    output tenyrPkg::wordT   imm,
    output logic             immRight,
    output logic             storing,
    output logic             derefRhs,
    output logic             branch,
    output logic             illegal
);

    import tenyrPkg::*;

    assign idxZ     = insn.z;
    assign idxX     = insn.x;
    assign idxY     = insn.y;
    assign op       = insn.op;
    assign imm      = {{20{insn.imm[11]}}, insn.imm}; // Sign extend
    assign immRight = insn.insnType;
    assign storing  = insn.storing;
    assign derefRhs = insn.derefRhs;

    assign illegal = &insn;                             // All-ones word
    assign branch  = (insn.z == REG_PC) && !insn.storing; // Store to pc is not a jump

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             we,
    input  tenyrPkg::regIdxT idxZ,
    input  tenyrPkg::regIdxT idxX,
    input  tenyrPkg::regIdxT idxY,
    input  tenyrPkg::wordT   writeZ,
    input  tenyrPkg::wordT   nextPc,
    output tenyrPkg::wordT   valZ,
    output tenyrPkg::wordT   valX,
    output tenyrPkg::wordT   valY
);

    import tenyrPkg::*;

    wordT regs [1:14]; // Only the general registers are stored

    function automatic wordT readPort(regIdxT idx, wordT pcPlusOne);
        wordT val;
        if (idx == REG_ZERO) begin
            val = '0;
        end else if (idx == REG_PC) begin
            val = pcPlusOne;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    assign valZ = readPort(idxZ, nextPc);
    assign valX = readPort(idxX, nextPc);
    assign valY = readPort(idxY, nextPc);

    always_ff @(posedge clk) begin
        if (we && idxZ != REG_ZERO && idxZ != REG_PC) begin
            regs[idxZ] <= writeZ;
        end
    end

endmodule

/* hdl/tenyrPkg.sv */
package tenyrPkg;

    typedef logic [31:0] wordT;
    typedef logic [3:0]  regIdxT;

    localparam regIdxT REG_ZERO = 4'd0;  // Always reads zero
    localparam regIdxT REG_PC   = 4'd15; // Reads as pc plus 1

    localparam wordT DEFAULT_RESET_VECTOR = 32'h0000_0000;

    // ALU operation codes in their ISA encoding
    typedef enum logic [3:0] {
        aluOr     = 4'h0,
        aluAnd    = 4'h1,
        aluAdd    = 4'h2,
        aluMul    = 4'h3,
        aluRsvd0  = 4'h4,
        aluShl    = 4'h5,
        aluCmpLt  = 4'h6,
        aluCmpEq  = 4'h7,
        aluCmpGt  = 4'h8,
        aluAndNot = 4'h9,
        aluXor    = 4'hA,
        aluSub    = 4'hB,
        aluXnor   = 4'hC,
        aluShr    = 4'hD,
        aluCmpNe  = 4'hE,
        aluRsvd1  = 4'hF
    } aluOpE;

    typedef struct packed {
        logic        guard;    // Set only in the illegal word
        logic        insnType; // Immediate in right position when set
        logic        storing;
        logic        derefRhs;
        regIdxT      z;
        regIdxT      x;
        regIdxT      y;
        aluOpE       op;
        logic [11:0] imm;
    } insnT;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        wordT        data;
    } storeEvtT;

endpackage

/* hdl/tenyrTop.sv */
`timescale 1ns/1ps

module tenyrTop #(
    parameter int             ADDR_W       = 8,
    parameter tenyrPkg::wordT RESET_VECTOR = tenyrPkg::DEFAULT_RESET_VECTOR
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               run,
    input  logic               loadEn,
    input  logic [ADDR_W-1:0]  loadAddr,
    input  tenyrPkg::insnT     loadInsn,
    output logic               halt,
    output tenyrPkg::storeEvtT store
);

    import tenyrPkg::*;

    logic [ADDR_W-1:0] pc, dAddr;
    insnT              insn;
    wordT              dOut, dIn;
    logic              dWrite;
    storeEvtT          storeQ;

    wordRam #(.ADDR_W(ADDR_W), .PAYLOAD_T(insnT)) uProgRam (
        .clk   (clk),
        .we    (loadEn && !run),  // Loading only while stopped
        .waddr (loadAddr),
        .wdata (loadInsn),
        .raddr (pc),
        .rdata (insn)
    );

    coreSeq #(.ADDR_W(ADDR_W), .RESET_VECTOR(RESET_VECTOR)) uCore (
        .clk     (clk),
        .reset_n (reset_n),
        .run     (run),
        .pc      (pc),
        .insn    (insn),
        .dAddr   (dAddr),
        .dWrite  (dWrite),
        .dOut    (dOut),
        .dIn     (dIn),
        .halt    (halt)
    );

    wordRam #(.ADDR_W(ADDR_W), .PAYLOAD_T(wordT)) uDataRam (
        .clk   (clk),
        .we    (dWrite),
        .waddr (dAddr),
        .wdata (dOut),
        .raddr (dAddr),
        .rdata (dIn)
    );

    // Store event lags the commit edge by one cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            storeQ.valid <= 1'b0;
        end else begin
            storeQ <= '{valid: dWrite, addr: 32'(dAddr), data: dOut};
        end
    end

    assign store = storeQ;

endmodule

/* hdl/wordRam.sv */
`timescale 1ns/1ps

module wordRam #(
    parameter int  ADDR_W    = 8,
    parameter type PAYLOAD_T = tenyrPkg::wordT
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  PAYLOAD_T          wdata,
    input  logic [ADDR_W-1:0] raddr,
    output PAYLOAD_T          rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    PAYLOAD_T mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read path is combinational so fetch and load finish in one cycle
    assign rdata = mem[raddr];

endmodule

/* verif/tenyrChecker.sv */
`timescale 1ns/1ps

module tenyrChecker (
    input logic               clk,
    input logic               reset_n,
    input logic               halt,
    input tenyrPkg::storeEvtT store
);

    import tenyrPkg::*;

    typedef struct packed {
        wordT       addr;
        wordT       data;
        logic       last;
        logic [7:0] testId;
    } expT;

    expT  expQ[$];
    logic haltSeen;
    int   errors   = 0;
    int   testErrs = 0;
    int   passCnt  = 0;
    int   failCnt  = 0;

    function automatic void pushExpect(wordT addr, wordT data, logic last, int id);
        expQ.push_back('{addr: addr, data: data, last: last, testId: 8'(id)});
    endfunction

    function automatic int pendingCount();
        return expQ.size();
    endfunction

    always @(posedge clk) begin
        expT e;
        haltSeen <= reset_n && halt;
        if (reset_n && store.valid) begin
            if (haltSeen) begin
                $display("Store event seen after halt at address %h", store.addr);
                errors++;
            end else if (expQ.size() == 0) begin
                $display("Store event arrived with none expected at address %h", store.addr);
                errors++;
            end else begin
                e = expQ.pop_front();
                if (store.addr !== e.addr) begin
                    $display("[ERROR] store.addr expected %h got %h", e.addr, store.addr);
                    testErrs++;
                end
                if (store.data !== e.data) begin
                    $display("[ERROR] store.data expected %h got %h", e.data, store.data);
                    testErrs++;
                end
                if (e.last) begin  // Last expected store closes the test
                    if (testErrs == 0) begin
                        $display("Test %0d passed", e.testId);
                        passCnt++;
                    end else begin
                        $display("Test %0d had %0d mismatches", e.testId, testErrs);
                        failCnt++;
                    end
                    testErrs = 0;
                end
            end
        end
    end

endmodule

/* verif/tenyrCore_properties.sv */
`timescale 1ns/1ps

module tenyrCore_properties (
    input logic clk,
    input logic reset_n,
    input logic halt,
    input logic dWrite
);

    haltSticky: assert property (@(posedge clk) halt |=> (halt || !reset_n))
        else $error("halt dropped without reset");

    noWriteHalted: assert property (@(posedge clk) disable iff (!reset_n) halt |-> !dWrite)
        else $error("data write while halted");

    writeSpacing: assert property (@(posedge clk) disable iff (!reset_n) dWrite |=> !dWrite)
        else $error("data writes on adjacent cycles");

    haltAfterReset: assert property (@(posedge clk) !reset_n |=> !halt)
        else $error("halt high after reset");

endmodule

bind coreSeq tenyrCore_properties props (
    .clk     (clk),
    .reset_n (reset_n),
    .halt    (halt),
    .dWrite  (dWrite)
);

/* verif/tenyrTb.sv */
`timescale 1ns/1ps

module tenyrTb;

    import tenyrPkg::*;

    localparam int ADDR_W = 8;

    logic     clk;
    logic     reset_n;
    logic     run;
    logic     loadEn;
    logic [ADDR_W-1:0] loadAddr;
    insnT     loadInsn;
    logic     halt;
    storeEvtT store;

    integer   seed;
    int       tbErrors;
    insnT     prog[$];
    wordT     refRegs [0:15];  // Kept across tests like the DUT registers
    wordT     refMem [0:255];

    tenyrTop #(.ADDR_W(ADDR_W), .RESET_VECTOR(32'h0)) DUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .run      (run),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadInsn (loadInsn),
        .halt     (halt),
        .store    (store)
    );

    tenyrChecker chk (
        .clk     (clk),
        .reset_n (reset_n),
        .halt    (halt),
        .store   (store)
    );

    always #5 clk = ~clk;

    function automatic insnT mk(logic t, logic st, logic dr, regIdxT z, regIdxT x,
                                regIdxT y, logic [3:0] op, logic [11:0] imm);
        insnT i;
        i.guard    = 1'b0;
        i.insnType = t;
        i.storing  = st;
        i.derefRhs = dr;
        i.z        = z;
        i.x        = x;
        i.y        = y;
        i.op       = aluOpE'(op);
        i.imm      = imm;
        return i;
    endfunction

    // ISA reference for one ALU result, addend included
    function automatic wordT aluRef(logic [3:0] op, wordT x, wordT y, wordT a);
        wordT r;
        case (op)
            4'h0: r = x | y;
            4'h1: r = x & y;
            4'h2: r = x + y;
            4'h3: r = x * y;
            4'h5: r = x << y[4:0];
            4'h6: r = ($signed(x) < $signed(y)) ? 32'hFFFF_FFFF : 32'h0;
            4'h7: r = (x == y) ? 32'hFFFF_FFFF : 32'h0;
            4'h8: r = ($signed(x) > $signed(y)) ? 32'hFFFF_FFFF : 32'h0;
            4'h9: r = x & ~y;
            4'hA: r = x ^ y;
            4'hB: r = x - y;
            4'hC: r = ~(x ^ y);
            4'hD: r = x >> y[4:0];
            4'hE: r = (x != y) ? 32'hFFFF_FFFF : 32'h0;
            default: r = 32'h0;
        endcase
        return r + a;
    endfunction

    function automatic wordT readReg(regIdxT idx, wordT pc);
        if (idx == 4'd0) return 32'h0;
        if (idx == 4'd15) return pc + 32'd1;
        return refRegs[idx];
    endfunction

    // Walks the program at ISA level and queues the expected stores
    function automatic int refRun(int id);
        wordT pc;
        wordT vx, vy, vz, imm, right, addend, rhs, wb, addr, data;
        insnT i;
        int   steps;
        wordT qa[$];
        wordT qd[$];
        pc = 32'h0;
        steps = 0;
        while (int'(pc) < prog.size() && steps < 1000) begin
            i = prog[pc];
            steps++;
            if (i == 32'hFFFF_FFFF) break;
            vx = readReg(i.x, pc);
            vy = readReg(i.y, pc);
            vz = readReg(i.z, pc);
            imm = {{20{i.imm[11]}}, i.imm};
            right  = i.insnType ? imm : vy;
            addend = i.insnType ? vy : imm;
            rhs = aluRef(i.op, vx, right, addend);
            if (i.storing) begin
                addr = (i.derefRhs ? rhs : vz) & 32'hFF;
                data = i.derefRhs ? vz : rhs;
                refMem[addr[7:0]] = data;
                qa.push_back(addr);
                qd.push_back(data);
                pc = (pc + 32'd1) & 32'hFF;
            end else begin
                wb = i.derefRhs ? refMem[rhs[7:0]] : rhs;
                if (i.z == 4'd15) begin
                    pc = wb & 32'hFF;  // Branch
                end else begin
                    if (i.z != 4'd0) refRegs[i.z] = wb;
                    pc = (pc + 32'd1) & 32'hFF;
                end
            end
        end
        for (int k = 0; k < qa.size(); k++) begin
            chk.pushExpect(qa[k], qd[k], k == qa.size() - 1, id);
        end
        return steps;
    endfunction

    task automatic emit(insnT i);
        prog.push_back(i);
    endtask

    task automatic ldi(regIdxT rd, logic [11:0] v);
        emit(mk(1'b0, 1'b0, 1'b0, rd, 4'd0, 4'd0, 4'h0, v));
    endtask

    // Builds a full word from 11-bit chunks
    task automatic ldi32(regIdxT rd, wordT v);
        ldi(rd, {2'b00, v[31:22]});
        emit(mk(1'b1, 1'b0, 1'b0, rd, rd, 4'd0, 4'h5, 12'd11));
        emit(mk(1'b1, 1'b0, 1'b0, rd, rd, 4'd0, 4'h0, {1'b0, v[21:11]}));
        emit(mk(1'b1, 1'b0, 1'b0, rd, rd, 4'd0, 4'h5, 12'd11));
        emit(mk(1'b1, 1'b0, 1'b0, rd, rd, 4'd0, 4'h0, {1'b0, v[10:0]}));
    endtask

    task automatic applyReset();
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset_n = 1'b1;
    endtask

    task automatic loadProgram();
        for (int k = 0; k < prog.size(); k++) begin
            loadEn   = 1'b1;
            loadAddr = ADDR_W'(k);
            loadInsn = prog[k];
            @(posedge clk);
            #1;
        end
        loadEn = 1'b0;
    endtask

    task automatic runTest(int id);
        int steps;
        int cyc;
        emit(32'hFFFF_FFFF);  // Every program ends on the illegal word
        applyReset();
        loadProgram();
        steps = refRun(id);
        run = 1'b1;
        cyc = 0;
        while (!halt && cyc < 4 * steps + 200) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!halt) begin
            $display("Core did not halt in time in test %0d", id);
            $display("Test failed");
            $finish;
        end
        repeat (8) @(posedge clk);
        #1;
        if (!halt) begin
            $display("Halt dropped while run stayed high in test %0d", id);
            tbErrors++;
        end
        if (chk.pendingCount() != 0) begin
            $display("Test %0d ended with %0d store events missing", id, chk.pendingCount());
            tbErrors++;
        end
        run = 1'b0;
        prog.delete();
    endtask

    initial begin
        wordT a;
        wordT b;
        clk      = 1'b0;
        reset_n  = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadInsn = '0;
        seed     = 32'hfb89_2e7f;
        tbErrors = 0;

        // ALU operations on random registers
        a = $random(seed);
        b = $random(seed);
        ldi32(4'd1, a);
        ldi32(4'd2, b);
        for (int op = 0; op < 16; op++) begin
            ldi(4'd3, 12'(op));
            emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd1, 4'd2, 4'(op), 12'($random(seed))));
        end
        runTest(1);

        // Operand layout with the type bit clear and set
        ldi32(4'd1, $random(seed));
        ldi32(4'd2, $random(seed));
        for (int k = 0; k < 4; k++) begin
            ldi(4'd3, 12'h20 + 12'(2 * k));
            emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd1, 4'd2, (k == 3) ? 4'h5 : 4'(k + 9), 12'h3A5));
            ldi(4'd3, 12'h21 + 12'(2 * k));
            emit(mk(1'b1, 1'b1, 1'b0, 4'd3, 4'd1, 4'd2, (k == 3) ? 4'h5 : 4'(k + 9), 12'h3A5));
        end
        runTest(2);

        // Loads and stores
        ldi32(4'd1, $random(seed));
        ldi(4'd4, 12'h40);
        emit(mk(1'b0, 1'b1, 1'b1, 4'd1, 4'd4, 4'd0, 4'h0, 12'd5));
        emit(mk(1'b0, 1'b0, 1'b1, 4'd5, 4'd4, 4'd0, 4'h0, 12'd5));
        ldi(4'd3, 12'h50);
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd5, 4'd0, 4'h0, 12'd0));
        emit(mk(1'b1, 1'b1, 1'b1, 4'd1, 4'd4, 4'd4, 4'h2, 12'd3));
        emit(mk(1'b0, 1'b0, 1'b1, 4'd6, 4'd0, 4'd0, 4'h0, 12'h83));
        emit(mk(1'b0, 1'b1, 1'b1, 4'd6, 4'd0, 4'd0, 4'h0, 12'h90));
        runTest(3);

        // Branch over two stores, then store pc plus 1
        ldi(4'd3, 12'h60);
        emit(mk(1'b0, 1'b0, 1'b0, 4'd15, 4'd15, 4'd0, 4'h0, 12'd2));
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 4'h0, 12'hBAD));
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 4'h0, 12'hBAD));
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd15, 4'd0, 4'h0, 12'd0));
        runTest(4);

        // Register 0 ignores writes
        emit(mk(1'b0, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, 4'h0, 12'h123));
        ldi(4'd3, 12'h70);
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 4'h2, 12'd7));
        runTest(5);

        // Nothing after the illegal word may store
        ldi(4'd3, 12'h78);
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 4'h0, 12'h055));
        emit(32'hFFFF_FFFF);
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 4'h0, 12'h066));
        emit(mk(1'b0, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 4'h0, 12'h077));
        runTest(6);

        $display("Tests passed %0d, failed %0d, other errors %0d",
                 chk.passCnt, chk.failCnt, chk.errors + tbErrors);
        if (chk.errors == 0 && tbErrors == 0 && chk.failCnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
